// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = coreTb
FILELIST  = rv32Core.f
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== design/aluUnit.sv ====
module aluUnit (
   input  logic                  clk,
   input  logic                  aluEn,
   input  rvPkg::wordT           rs1,
   input  rvPkg::wordT           rs2,
   input  rvPkg::wordT           immI,
   input  logic                  useRs2,
   input  rvPkg::funct3OneHotT   funct3Is,
   input  logic                  altFunct,
   output rvPkg::wordT           aluOut,
   output rvPkg::wordT           sum,
   output logic                  predicate
);
   import rvPkg::*;

   wordT              aluIn2;
   logic [xlen:0]     diff;
   logic              lt;
   logic              ltu;
   logic              eq;
   wordT              shifterIn;
   logic signed [xlen:0] shiftExt;
   logic [xlen:0]     shiftRaw;
   wordT              shiftRight;
   wordT              result;

   // Bit reversal lets one right shifter do left shifts too
   function automatic wordT reverseBits(input wordT x);
      wordT r;
      for (int i = 0; i < xlen; i++) begin
         r[i] = x[xlen-1-i];
      end
      return r;
   endfunction

   // Register ops and branches compare rs2, the rest use the I immediate
   assign aluIn2 = useRs2 ? rs2 : immI;

   // Also the JALR target and load/store effective address form
   assign sum = rs1 + aluIn2;

   // One 33-bit subtract gives SUB and all compares
   assign diff = {1'b1, ~aluIn2} + {1'b0, rs1} + 33'd1;
   assign ltu = diff[xlen];
   // Signs differ: rs1 is less exactly when it is negative
   assign lt = (rs1[xlen-1] ^ aluIn2[xlen-1]) ? rs1[xlen-1] : diff[xlen];
   assign eq = (diff[xlen-1:0] == '0);

   // SLL reverses input and output around the right shifter
   assign shifterIn = funct3Is[1] ? reverseBits(rs1) : rs1;
   // Extra top bit carries the fill for SRA
   assign shiftExt = {altFunct & rs1[xlen-1], shifterIn};
   assign shiftRaw = shiftExt >>> aluIn2[4:0];
   assign shiftRight = shiftRaw[xlen-1:0];

   always_comb begin
      unique case (1'b1)
         funct3Is[0]: result = altFunct ? diff[xlen-1:0] : sum;
         funct3Is[1]: result = reverseBits(shiftRight);
         funct3Is[2]: result = wordT'(lt);
         funct3Is[3]: result = wordT'(ltu);
         funct3Is[4]: result = rs1 ^ aluIn2;
         funct3Is[5]: result = shiftRight;
         funct3Is[6]: result = rs1 | aluIn2;
         default:     result = rs1 & aluIn2;
      endcase
   end

   // Result held for write-back in execute2
   always_ff @(posedge clk) begin
      if (aluEn) begin
         aluOut <= result;
      end
   end

   // Branch condition, funct3 2 and 3 are not branches
   assign predicate = (funct3Is[0] & eq) |
                      (funct3Is[1] & ~eq) |
                      (funct3Is[4] & lt) |
                      (funct3Is[5] & ~lt) |
                      (funct3Is[6] & ltu) |
                      (funct3Is[7] & ~ltu);

endmodule

// ==== design/controlSequencer.sv ====
module controlSequencer #(
   parameter rvPkg::wordT resetAddr = '0,
   parameter int          addrWidth = 24
) (
   input  logic                  clk,
   input  logic                  reset,
   input  rvPkg::opcodeT         opcode,
   input  logic                  predicate,
   input  rvPkg::wordT           immB,
   input  rvPkg::wordT           immJ,
   input  rvPkg::wordT           immU,
   input  rvPkg::wordT           immI,
   input  rvPkg::wordT           immS,
   input  rvPkg::wordT           rs1,
   input  rvPkg::wordT           sum,
   input  rvPkg::wordT           aluOut,
   input  rvPkg::wordT           loadData,
   input  rvPkg::wordT           memRdata,
   input  logic                  memRbusy,
   input  logic                  memWbusy,
   output logic [addrWidth-1:0]  pc,
   output rvPkg::wordT           instr,
   output rvPkg::wordT           memAddr,
   output logic                  memRstrb,
   output logic                  instrLatch,
   output logic                  aluEn,
   output logic                  storeActive,
   output logic                  writeEn,
   output rvPkg::wordT           writeData
);
   import rvPkg::*;

   seqStateT             state;
   logic [addrWidth-1:0] pcPlus4;
   logic [addrWidth-1:0] pcPlusImm;
   logic [addrWidth-1:0] lsAddr;
   logic [addrWidth-1:0] addrSel;
   logic                 predicateReg;
   wordT                 immTarget;
   wordT                 immOffset;
   logic                 isLoad;
   logic                 isStore;
   logic                 isJal;
   logic                 isJalr;
   logic                 isBranch;
   logic                 writesRd;

   assign isLoad   = (opcode == opLoad);
   assign isStore  = (opcode == opStore);
   assign isJal    = (opcode == opJal);
   assign isJalr   = (opcode == opJalr);
   assign isBranch = (opcode == opBranch);

   // SYSTEM and unknown opcodes never write a register
   assign writesRd = isLoad || isJal || isJalr || (opcode == opLui) ||
                     (opcode == opAuipc) || (opcode == opAluImm) || (opcode == opAluReg);

   assign pcPlus4 = pc + addrWidth'(4);

   // Shared PC adder for branch, JAL and AUIPC
   assign immTarget = isJal ? immJ : ((opcode == opAuipc) ? immU : immB);
   assign immOffset = isStore ? immS : immI;

   // Fetch uses the PC, everything after uses the load/store address
   assign addrSel = ((state == fetchInstr) || (state == waitInstr)) ? pc : lsAddr;
   assign memAddr = xlen'(addrSel);

   assign instrLatch  = (state == waitInstr) && !memRbusy;
   assign aluEn       = (state == execute1);
   assign storeActive = (state == execute2) && isStore;
   assign memRstrb    = (state == fetchInstr) || ((state == execute2) && isLoad);

   // Loads write back once the data arrives in waitMem
   assign writeEn = ((state == execute2) && writesRd && !isLoad) ||
                    ((state == waitMem) && isLoad);

   always_comb begin
      case (opcode)
         opLui:              writeData = immU;
         opAuipc:            writeData = xlen'(pcPlusImm);
         opJal, opJalr:      writeData = xlen'(pcPlus4);
         opAluImm, opAluReg: writeData = aluOut;
         opLoad:             writeData = loadData;
         default:            writeData = '0;
      endcase
   end

   // State and PC
   always_ff @(posedge clk) begin
      if (!reset) begin
         // Start by waiting out any store still in progress
         state <= waitMem;
         pc    <= resetAddr[addrWidth-1:0];
      end else begin
         unique case (state)
            fetchInstr: state <= waitInstr;
            waitInstr: begin
               if (!memRbusy) begin
                  state <= execute1;
               end
            end
            execute1: state <= execute2;
            execute2: begin
               // JALR clears bit 0 of its target
               if (isJalr) begin
                  pc <= {sum[addrWidth-1:1], 1'b0};
               end else if (isJal || (isBranch && predicateReg)) begin
                  pc <= pcPlusImm;
               end else begin
                  pc <= pcPlus4;
               end
               state <= (isLoad || isStore) ? waitMem : fetchInstr;
            end
            default: begin
               // waitMem
               if (!memRbusy && !memWbusy) begin
                  state <= fetchInstr;
               end
            end
         endcase
      end
   end

   // Instruction and execute1 results
   always_ff @(posedge clk) begin
      if (instrLatch) begin
         instr <= memRdata;
      end
      if (state == execute1) begin
         pcPlusImm    <= pc + immTarget[addrWidth-1:0];
         lsAddr       <= rs1[addrWidth-1:0] + immOffset[addrWidth-1:0];
         predicateReg <= predicate;
      end
   end

   // Jump and branch targets must stay word aligned
   assert property (@(posedge clk) disable iff (!reset) pc[1:0] == 2'b00);

endmodule

// ==== design/instrDecoder.sv ====
module instrDecoder (
   input  rvPkg::wordT                     instr,
   output rvPkg::opcodeT                   opcode,
   output rvPkg::funct3OneHotT             funct3Is,
   output logic [rvPkg::regIdxWidth-1:0]   rdId,
   output logic                            altFunct,
   output logic                            useRs2,
   output logic                            loadUnsigned,
   output rvPkg::wordT                     immI,
   output rvPkg::wordT                     immS,
   output rvPkg::wordT                     immB,
   output rvPkg::wordT                     immJ,
   output rvPkg::wordT                     immU
);
   import rvPkg::*;

   // Major opcode, low two bits are always 11 in RV32I
   assign opcode = opcodeT'(instr[6:2]);

   // Destination register
   assign rdId = instr[11:7];

   // One-hot funct3 keeps the ALU and lane muxes flat
   assign funct3Is = funct3OneHotT'(8'b0000_0001 << instr[14:12]);

   // Bit 30 selects SUB only in register form, since ADDI uses it as immediate
   // SRA and SRAI both carry it in funct7
   assign altFunct = instr[30] & (instr[5] | funct3Is[5]);

   // Second ALU operand is rs2 for register ops and branch compares
   assign useRs2 = (opcode == opAluReg) || (opcode == opBranch);

   // funct3 bit 2 marks LBU and LHU
   assign loadUnsigned = instr[14];

   // Immediate formats
   assign immI = {{21{instr[31]}}, instr[30:20]};
   assign immS = {{21{instr[31]}}, instr[30:25], instr[11:7]};
   assign immB = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   assign immJ = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
   assign immU = {instr[31:12], 12'b0};

endmodule

// ==== design/loadStoreAlign.sv ====
module loadStoreAlign #(
   parameter int addrWidth = 24
) (
   input  logic [addrWidth-1:0]  lsAddr,
   input  rvPkg::funct3OneHotT   funct3Is,
   input  logic                  loadUnsigned,
   input  rvPkg::wordT           memRdata,
   input  rvPkg::wordT           rs2,
   input  logic                  storeActive,
   output rvPkg::wordT           loadData,
   output rvPkg::wordT           memWdata,
   output rvPkg::maskT           memWmask
);
   import rvPkg::*;

   logic        byteAccess;
   logic        halfAccess;
   logic [15:0] loadHalf;
   logic [7:0]  loadByte;
   logic        loadSign;
   maskT        laneMask;

   // funct3 low bits give the size, 4 and 5 are the unsigned loads
   assign byteAccess = funct3Is[0] | funct3Is[4];
   assign halfAccess = funct3Is[1] | funct3Is[5];

   // Address bit 1 picks the halfword, bit 0 the byte within it
   assign loadHalf = lsAddr[1] ? memRdata[31:16] : memRdata[15:0];
   assign loadByte = lsAddr[0] ? loadHalf[15:8] : loadHalf[7:0];

   assign loadSign = ~loadUnsigned & (byteAccess ? loadByte[7] : loadHalf[15]);

   assign loadData = byteAccess ? {{24{loadSign}}, loadByte} :
                     halfAccess ? {{16{loadSign}}, loadHalf} :
                                  memRdata;

   // Replicate store data so the selected lane always holds it
   assign memWdata[7:0]   = rs2[7:0];
   assign memWdata[15:8]  = lsAddr[0] ? rs2[7:0] : rs2[15:8];
   assign memWdata[23:16] = lsAddr[1] ? rs2[7:0] : rs2[23:16];
   assign memWdata[31:24] = lsAddr[0] ? rs2[7:0] :
                            lsAddr[1] ? rs2[15:8] : rs2[31:24];

   // One lane for bytes, two for halfwords, all four for words
   always_comb begin
      if (byteAccess) begin
         laneMask = maskT'(4'b0001 << lsAddr[1:0]);
      end else if (halfAccess) begin
         laneMask = lsAddr[1] ? 4'b1100 : 4'b0011;
      end else begin
         laneMask = 4'b1111;
      end
   end

   // Mask is the write strobe itself
   assign memWmask = storeActive ? laneMask : 4'b0000;

   always_comb begin
      if (storeActive && halfAccess) begin
         assert #0 (lsAddr[0] == 1'b0)
            else $error("misaligned halfword store at %h", lsAddr);
      end
   end

endmodule

// ==== design/registerFile.sv ====
module registerFile (
   input  logic                           clk,
   input  logic                           readEn,
   input  logic [rvPkg::regIdxWidth-1:0]  rs1Id,
   input  logic [rvPkg::regIdxWidth-1:0]  rs2Id,
   output rvPkg::wordT                    rs1,
   output rvPkg::wordT                    rs2,
   input  logic                           writeEn,
   input  logic [rvPkg::regIdxWidth-1:0]  rdId,
   input  rvPkg::wordT                    writeData
);
   import rvPkg::*;

   // Register storage, entry 0 is never written
   wordT regs [2**regIdxWidth];

   always_ff @(posedge clk) begin
      if (writeEn && (rdId != '0)) begin
         regs[rdId] <= writeData;
      end
      // Reads happen in waitInstr, writes only in execute2 or waitMem
      if (readEn) begin
         rs1 <= (rs1Id == '0) ? '0 : regs[rs1Id];
         rs2 <= (rs2Id == '0) ? '0 : regs[rs2Id];
      end
   end

   // A read never shares its cycle with a write-back
   assert property (@(posedge clk) readEn |-> !writeEn);

endmodule

// ==== design/rv32Core.sv ====
module rv32Core #(
   parameter rvPkg::wordT resetAddr = '0,
   parameter int          addrWidth = 24
) (
   input  logic         clk,
   input  logic         reset,
   output rvPkg::wordT  memAddr,
   output rvPkg::wordT  memWdata,
   output rvPkg::maskT  memWmask,
   input  rvPkg::wordT  memRdata,
   output logic         memRstrb,
   input  logic         memRbusy,
   input  logic         memWbusy
);
   import rvPkg::*;

   // Decoded fields
   wordT                   instr;
   opcodeT                 opcode;
   funct3OneHotT           funct3Is;
   logic [regIdxWidth-1:0] rdId;
   logic                   altFunct;
   logic                   useRs2;
   logic                   loadUnsigned;
   wordT                   immI;
   wordT                   immS;
   wordT                   immB;
   wordT                   immJ;
   wordT                   immU;

   // Datapath
   wordT                   rs1;
   wordT                   rs2;
   wordT                   aluOut;
   wordT                   sum;
   logic                   predicate;
   wordT                   loadData;
   wordT                   writeData;

   // Sequencer controls
   logic                   instrLatch;
   logic                   aluEn;
   logic                   storeActive;
   logic                   writeEn;

   instrDecoder decoder (
      .instr(instr), .opcode(opcode), .funct3Is(funct3Is), .rdId(rdId),
      .altFunct(altFunct), .useRs2(useRs2), .loadUnsigned(loadUnsigned),
      .immI(immI), .immS(immS), .immB(immB), .immJ(immJ), .immU(immU)
   );

   // Register indices come straight from the bus while the instruction arrives
   registerFile regFile (
      .clk(clk), .readEn(instrLatch),
      .rs1Id(memRdata[19:15]), .rs2Id(memRdata[24:20]),
      .rs1(rs1), .rs2(rs2),
      .writeEn(writeEn), .rdId(rdId), .writeData(writeData)
   );

   aluUnit alu (
      .clk(clk), .aluEn(aluEn), .rs1(rs1), .rs2(rs2), .immI(immI),
      .useRs2(useRs2), .funct3Is(funct3Is), .altFunct(altFunct),
      .aluOut(aluOut), .sum(sum), .predicate(predicate)
   );

   // memAddr holds the load/store address whenever lanes matter
   loadStoreAlign #(.addrWidth(addrWidth)) lsAlign (
      .lsAddr(memAddr[addrWidth-1:0]), .funct3Is(funct3Is),
      .loadUnsigned(loadUnsigned), .memRdata(memRdata), .rs2(rs2),
      .storeActive(storeActive), .loadData(loadData),
      .memWdata(memWdata), .memWmask(memWmask)
   );

   // The PC only matters inside the sequencer
   controlSequencer #(.resetAddr(resetAddr), .addrWidth(addrWidth)) sequencer (
      .clk(clk), .reset(reset), .opcode(opcode), .predicate(predicate),
      .immB(immB), .immJ(immJ), .immU(immU), .immI(immI), .immS(immS),
      .rs1(rs1), .sum(sum), .aluOut(aluOut), .loadData(loadData),
      .memRdata(memRdata), .memRbusy(memRbusy), .memWbusy(memWbusy),
      .pc(), .instr(instr), .memAddr(memAddr), .memRstrb(memRstrb),
      .instrLatch(instrLatch), .aluEn(aluEn), .storeActive(storeActive),
      .writeEn(writeEn), .writeData(writeData)
   );

endmodule

// ==== design/rvPkg.sv ====
package rvPkg;

   // Data word width
   localparam int xlen = 32;
   // Register index width, 32 registers
   localparam int regIdxWidth = 5;

   // One data word
   typedef logic [xlen-1:0] wordT;

   // Byte write mask, bit n enables byte lane n
   typedef logic [3:0] maskT;

   // One-hot funct3, bit n set when funct3 == n
   typedef logic [7:0] funct3OneHotT;

   // The ten RV32I major opcodes, instruction bits 6..2
   typedef enum logic [4:0] {
      opLoad   = 5'b00000,
      opAluImm = 5'b00100,
      opAuipc  = 5'b00101,
      opStore  = 5'b01000,
      opAluReg = 5'b01100,
      opLui    = 5'b01101,
      opBranch = 5'b11000,
      opJalr   = 5'b11001,
      opJal    = 5'b11011,
      opSystem = 5'b11100
   } opcodeT;

   // Sequencer states, one-hot
   typedef enum logic [4:0] {
      fetchInstr = 5'b00001,
      waitInstr  = 5'b00010,
      execute1   = 5'b00100,
      execute2   = 5'b01000,
      waitMem    = 5'b10000
   } seqStateT;

endpackage

// ==== rv32Core.f ====
design/rvPkg.sv
design/instrDecoder.sv
design/registerFile.sv
design/aluUnit.sv
design/loadStoreAlign.sv
design/controlSequencer.sv
design/rv32Core.sv
verif/storeChecker.sv
verif/coreTb.sv

// ==== verif/coreGolden.mem ====
// Header: program words, executed instruction count, store count
// Then program words, then store records: name index, address, data, mask
00000052 00000047 0000001C
// ALU setup and results, x10 = 0x200, x1 = -7, x2 = 3
20000513 FF900093 00300113 002081B3 00352023 40208233 00452223 4020D293
00552423 00209333 00652623 0020D3B3 00752823 0F00C413 00852A23 0020E4B3
00952C23 0FF0F593 00B52E23
// slt, sltu and their stores
0020A633 0020B6B3 02C52023 02D52223
// Taken branches skip an add to x15
00210463 00178793 00209463 00278793 0020C463 00478793 00115463 00878793
00116463 01078793 0020F463 02078793
// Not-taken branches fall into an add to x16
00208463 00180813 00211463 00280813 00114463 00480813 0020D463 00880813
0020E463 01080813 00117463 02080813
02F52423 03052623
// lui, auipc, jal, jalr
123458B7 03152823 00001917 03252A23 008009EF 00000993 03352C23 0ED00A13
003A0AE7 00000A93 00000A93 03552E23
// Byte and halfword stores of 0x12345678
67888B13 05650023 056500A3 05650123 056501A3 05651223 05651323
// Loads from the data word at 0x144, each stored back
F4550C03 F4650C83 F4454D03 F4651D83 F4655E03 F4451E83
05852423 05952623 05A52823 05B52A23 05C52C23 05D52E23
// Idle loop, then the data word
0000006F F2837F81
// Store records
00000000 00000200 FFFFFFFC 0000000F
00000001 00000204 FFFFFFF6 0000000F
00000002 00000208 FFFFFFFE 0000000F
00000003 0000020C FFFFFFC8 0000000F
00000004 00000210 1FFFFFFF 0000000F
00000005 00000214 FFFFFF09 0000000F
00000006 00000218 FFFFFFFB 0000000F
00000007 0000021C 000000F9 0000000F
00000008 00000220 00000001 0000000F
00000009 00000224 00000000 0000000F
0000000A 00000228 00000000 0000000F
0000000B 0000022C 0000003F 0000000F
0000000C 00000230 12345000 0000000F
0000000D 00000234 000010CC 0000000F
0000000E 00000238 000000D8 0000000F
0000000F 0000023C 000000E8 0000000F
00000010 00000240 78787878 00000001
00000011 00000241 78787878 00000002
00000012 00000242 78787878 00000004
00000013 00000243 78787878 00000008
00000014 00000244 56785678 00000003
00000015 00000246 56785678 0000000C
00000016 00000248 0000007F 0000000F
00000017 0000024C FFFFFF83 0000000F
00000018 00000250 00000081 0000000F
00000019 00000254 FFFFF283 0000000F
0000001A 00000258 0000F283 0000000F
0000001B 0000025C 00007F81 0000000F

// ==== verif/coreTb.sv ====
module coreTb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int goldenSize = 197;
   localparam int memWords = 256;

   logic        clk;
   logic        reset;
   logic [31:0] memAddr;
   logic [31:0] memWdata;
   logic [3:0]  memWmask;
   logic [31:0] memRdata;
   logic        memRstrb;
   logic        memRbusy;
   logic        memWbusy;

   logic [31:0] golden [goldenSize];
   logic [31:0] mem [memWords];
   integer      seed;
   int          rBusyLeft;
   int          wBusyLeft;
   int          cycles;
   int          cycleLimit;
   int          passCount;
   int          failCount;
   logic        storesDone;

   rv32Core #(.resetAddr(32'h0), .addrWidth(24)) uut (
      .clk(clk), .reset(reset), .memAddr(memAddr), .memWdata(memWdata),
      .memWmask(memWmask), .memRdata(memRdata), .memRstrb(memRstrb),
      .memRbusy(memRbusy), .memWbusy(memWbusy)
   );

   storeChecker #(.goldenSize(goldenSize)) chk (
      .clk(clk), .reset(reset), .memAddr(memAddr), .memWdata(memWdata),
      .memWmask(memWmask), .golden(golden), .passCount(passCount),
      .failCount(failCount), .storesDone(storesDone)
   );

   always #10 clk = ~clk;

   // Memory model, word addressed, answers on the falling edge
   always @(negedge clk) begin
      for (int i = 0; i < 4; i++) begin
         if (memWmask[i]) begin
            mem[memAddr[9:2]][8*i +: 8] = memWdata[8*i +: 8];
         end
      end
      // Read data only moves on a strobe
      if (memRstrb) begin
         memRdata <= mem[memAddr[9:2]];
      end
      // Read busy, 1 in 4 strobes stall for 1 to 3 cycles
      if (rBusyLeft != 0) begin
         rBusyLeft--;
      end else if (memRstrb && (($random(seed) & 3) == 0)) begin
         rBusyLeft = 1 + int'($unsigned($random(seed)) % 3);
      end
      memRbusy <= (rBusyLeft != 0);
      // Write busy works the same way on stores
      if (wBusyLeft != 0) begin
         wBusyLeft--;
      end else if ((memWmask != 4'b0000) && (($random(seed) & 3) == 0)) begin
         wBusyLeft = 1 + int'($unsigned($random(seed)) % 3);
      end
      memWbusy <= (wBusyLeft != 0);
   end

   // Run limit from the executed instruction count
   initial begin
      @(posedge reset);
      while (!storesDone && (cycles < cycleLimit)) begin
         @(posedge clk);
         cycles++;
      end
      if (!storesDone) begin
         $display("timeout: stores still missing after %0d cycles", cycles);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   initial begin
      seed = 32'h9a55;
      clk = 1'b0;
      reset = 1'b0;
      memRdata = '0;
      memRbusy = 1'b0;
      memWbusy = 1'b0;
      rBusyLeft = 0;
      wBusyLeft = 0;
      cycles = 0;
      $readmemh("verif/coreGolden.mem", golden);
      // Unused words hold their own address tag
      for (int i = 0; i < memWords; i++) begin
         mem[i] = 32'hdead0000 | i;
      end
      for (int i = 0; i < int'(golden[0]); i++) begin
         mem[i] = golden[3 + i];
      end
      // Worst case 5 cycles plus 4 busy per instruction, doubled
      cycleLimit = int'(golden[1]) * (5 + 4) * 2;
      repeat (3) @(posedge clk);
      @(negedge clk);
      reset = 1'b1;
      while (!storesDone) begin
         @(posedge clk);
      end
      @(negedge clk);
      $display("summary: %0d stores passed, %0d stores failed", passCount, failCount);
      if (failCount == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

// ==== verif/storeChecker.sv ====
module storeChecker #(
   parameter int goldenSize = 197
) (
   input  logic        clk,
   input  logic        reset,
   input  logic [31:0] memAddr,
   input  logic [31:0] memWdata,
   input  logic [3:0]  memWmask,
   input  logic [31:0] golden [goldenSize],
   output int          passCount,
   output int          failCount,
   output logic        storesDone
);
   timeunit 1ns;
   timeprecision 1ps;

   int          storeIdx;
   int          base;
   string       name;
   logic [31:0] expAddr;
   logic [31:0] expData;
   logic [3:0]  expMask;
   logic [31:0] lanes;

   // Test names in golden record order
   function automatic string nameOfTest(input int idx);
      string names [28] = '{"add", "sub", "srai", "sll", "srl", "xori", "or", "andi",
                            "slt", "sltu", "branchTaken", "branchNotTaken", "lui",
                            "auipc", "jalLink", "jalrLink", "sbLane0", "sbLane1",
                            "sbLane2", "sbLane3", "shLow", "shHigh", "lbPos", "lbNeg",
                            "lbu", "lhNeg", "lhu", "lhPos"};
      if (idx >= 0 && idx < 28) begin
         return names[idx];
      end
      return "unknown";
   endfunction

   // Byte mask widened to bit lanes
   function automatic logic [31:0] laneBits(input logic [3:0] m);
      logic [31:0] r;
      for (int i = 0; i < 4; i++) begin
         r[8*i +: 8] = {8{m[i]}};
      end
      return r;
   endfunction

   initial begin
      passCount = 0;
      failCount = 0;
      storeIdx = 0;
      storesDone = 1'b0;
   end

   // Store outputs settle after the rising edge, so sample on the falling one
   always @(negedge clk) begin
      if (reset && (memWmask != 4'b0000)) begin
         if (storeIdx >= int'(golden[2])) begin
            $display("extra store to address %h after the last expected store", memAddr);
            failCount++;
         end else begin
            base = 3 + int'(golden[0]) + 4 * storeIdx;
            name = nameOfTest(int'(golden[base]));
            expAddr = golden[base + 1];
            expData = golden[base + 2];
            expMask = golden[base + 3][3:0];
            // Only enabled lanes carry meaning
            lanes = laneBits(expMask);
            if ((memAddr !== expAddr) || (memWmask !== expMask) ||
                ((memWdata & lanes) !== (expData & lanes))) begin
               // Fields are address, data and mask
               $display("mismatch %s: expected %h/%h/%b, actual %h/%h/%b",
                        name, expAddr, expData & lanes, expMask,
                        memAddr, memWdata & lanes, memWmask);
               failCount++;
            end else begin
               $display("pass %s: addr %h data %h mask %b", name, memAddr,
                        memWdata & lanes, memWmask);
               passCount++;
            end
            storeIdx++;
            if (storeIdx == int'(golden[2])) begin
               storesDone = 1'b1;
            end
         end
      end
   end

endmodule
